// File: project.f
rtl/g729Pkg.sv
rtl/basicOps.sv
rtl/lspTableRom.sv
rtl/scratchMem.sv
rtl/lsfLspConvert.sv
rtl/lsfLspTop.sv
tb/lsfLspAsserts.sv
tb/lsfLspTb.sv

// File: rtl/basicOps.sv
`timescale 1ns/10ps

module basicOps
(
	input  logic signed [15:0] multA,
	input  logic signed [15:0] multB,
	output logic signed [15:0] multResult,
	input  logic signed [15:0] shrValue,
	input  logic signed [15:0] shrCount,
	output logic signed [15:0] shrResult,
	input  logic signed [15:0] subA,
	input  logic signed [15:0] subB,
	output logic signed [15:0] subResult,
	input  logic signed [15:0] lMultA,
	input  logic signed [15:0] lMultB,
	output logic signed [31:0] lMultResult,
	input  logic signed [15:0] addA,
	input  logic signed [15:0] addB,
	output logic signed [15:0] addResult,
	input  logic signed [31:0] lShrValue,
	input  logic signed [15:0] lShrCount,
	output logic signed [31:0] lShrResult
);
	logic signed [31:0] multProd;
	logic signed [31:0] lMultProd;
	logic signed [16:0] shrNeg;
	logic signed [16:0] lShrNeg;
	logic [4:0] shlAmt;
	logic [5:0] lShlAmt;

	function automatic logic signed [15:0] sat16(input logic signed [31:0] v);
		if (v > 32'sd32767)
			return 16'sh7fff;
		else if (v < -32'sd32768)
			return 16'sh8000;
		else
			return v[15:0];
	endfunction

	function automatic logic signed [31:0] sat32(input logic signed [63:0] v);
		if (v > 64'sh0000_0000_7fff_ffff)
			return 32'sh7fff_ffff;
		else if (v < -64'sh0000_0000_8000_0000)
			return 32'sh8000_0000;
		else
			return v[31:0];
	endfunction

	// Q15 multiply, only -1 * -1 can overflow
	assign multProd = multA * multB;
	assign multResult = sat16(multProd >>> 15);

	assign subResult = sat16(32'(subA) - 32'(subB));
	assign addResult = sat16(32'(addA) + 32'(addB));

	// Doubled product, 0x40000000 would wrap to the sign bit
	assign lMultProd = lMultA * lMultB;
	assign lMultResult = (lMultProd == 32'sh4000_0000) ? 32'sh7fff_ffff : (lMultProd <<< 1);

	// Negative count turns into a saturating left shift
	always_comb
	begin
		shrNeg = -17'(shrCount);
		shlAmt = (shrNeg > 17'sd16) ? 5'd16 : shrNeg[4:0];
		if (shrCount < 0)
			shrResult = sat16(32'(shrValue) <<< shlAmt);
		else if (shrCount > 16'sd15)
			shrResult = shrValue >>> 15;
		else
			shrResult = shrValue >>> shrCount[3:0];
	end

	always_comb
	begin
		lShrNeg = -17'(lShrCount);
		lShlAmt = (lShrNeg > 17'sd32) ? 6'd32 : lShrNeg[5:0];
		if (lShrCount < 0)
			lShrResult = sat32(64'(lShrValue) <<< lShlAmt);
		else if (lShrCount > 16'sd31)
			lShrResult = lShrValue >>> 31;
		else
			lShrResult = lShrValue >>> lShrCount[4:0];
	end

endmodule

// File: rtl/g729Pkg.sv
package g729Pkg;

	// Frame and memory geometry
	localparam int lpcOrder = 10;
	localparam int memAddrWidth = 7;
	localparam int blockWidth = 3;
	localparam int romAddrWidth = 7;

	// Constant ROM regions
	localparam logic [romAddrWidth-1:0] cosTableBase = 7'd0;
	localparam logic [romAddrWidth-1:0] slopeTableBase = 7'd64;

	// Lsf_lsp2 arithmetic constants
	localparam logic [15:0] freqScale = 16'd20861;
	localparam logic [15:0] offsetShift = 16'd8;
	localparam logic [15:0] slopeShift = 16'd13;
	localparam logic [15:0] maxIndex = 16'd63;

	// Conversion engine states
	localparam logic [2:0] stateIdle = 3'd0;
	localparam logic [2:0] stateScale = 3'd1;
	localparam logic [2:0] stateClamp = 3'd2;
	localparam logic [2:0] stateSlope = 3'd3;
	localparam logic [2:0] stateWrite = 3'd4;
	localparam logic [2:0] stateAdvance = 3'd5;

	//////////////////////////////////////////////////////////////////////////////
	// G.729 table2, cos(pi*k/64) in Q15
	//////////////////////////////////////////////////////////////////////////////
	localparam logic signed [15:0] cosTable [0:64] = '{
		32767,  32729,  32610,  32413,  32138,  31786,  31357,  30853,
		30274,  29622,  28899,  28106,  27246,  26320,  25330,  24279,
		23170,  22006,  20788,  19520,  18205,  16846,  15447,  14010,
		12540,  11039,   9512,   7962,   6393,   4808,   3212,   1608,
		    0,  -1608,  -3212,  -4808,  -6393,  -7962,  -9512, -11039,
		-12540, -14010, -15447, -16846, -18205, -19520, -20788, -22006,
		-23170, -24279, -25330, -26320, -27246, -28106, -28899, -29622,
		-30274, -30853, -31357, -31786, -32138, -32413, -32610, -32729,
		-32768
	};

	//////////////////////////////////////////////////////////////////////////////
	// G.729 slope_cos, segment slopes for the interpolation
	//////////////////////////////////////////////////////////////////////////////
	localparam logic signed [15:0] slopeTable [0:63] = '{
		  -632,  -1893,  -3150,  -4399,  -5638,  -6863,  -8072,  -9261,
		-10428, -11570, -12684, -13767, -14817, -15832, -16808, -17744,
		-18637, -19486, -20287, -21039, -21741, -22390, -22986, -23526,
		-24009, -24435, -24801, -25108, -25354, -25540, -25664, -25726,
		-25726, -25664, -25540, -25354, -25108, -24801, -24435, -24009,
		-23526, -22986, -22390, -21741, -21039, -20287, -19486, -18637,
		-17744, -16808, -15832, -14817, -13767, -12684, -11570, -10428,
		 -9261,  -8072,  -6863,  -5638,  -4399,  -3150,  -1893,   -632
	};

endpackage

// File: rtl/lsfLspConvert.sv
`timescale 1ns/10ps

module lsfLspConvert
	import g729Pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic start,
	input  logic [blockWidth-1:0] lsfBlock,
	input  logic [blockWidth-1:0] lspBlock,
	output logic [15:0] multA,
	output logic [15:0] multB,
	input  logic [15:0] multResult,
	output logic [15:0] shrValue,
	output logic [15:0] shrCount,
	input  logic [15:0] shrResult,
	output logic [15:0] subA,
	output logic [15:0] subB,
	input  logic [15:0] subResult,
	output logic [15:0] lMultA,
	output logic [15:0] lMultB,
	input  logic [31:0] lMultResult,
	output logic [15:0] addA,
	output logic [15:0] addB,
	input  logic [15:0] addResult,
	output logic [31:0] lShrValue,
	output logic [15:0] lShrCount,
	input  logic [31:0] lShrResult,
	output logic [romAddrWidth-1:0] romAddr,
	input  logic [15:0] romData,
	output logic [memAddrWidth-1:0] memReadAddr,
	input  logic [31:0] memReadData,
	output logic [memAddrWidth-1:0] memWriteAddr,
	output logic [31:0] memWriteData,
	output logic memWriteEn,
	output logic busy,
	output logic done
);
	logic [2:0] state, stateNext;
	logic [3:0] i, iNext;
	logic [15:0] ind, indNext;
	logic [15:0] offset, offsetNext;
	logic [31:0] lTemp, lTempNext;
	logic [15:0] clampedInd;

	////////////////////////////////////////////////////////////////////////////
	// Registers
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= stateIdle;
			i <= '0;
		end
		else
		begin
			state <= stateNext;
			i <= iNext;
		end
	end

	// Datapath values, only meaningful inside a coefficient
	always_ff @(posedge clk)
	begin
		ind <= indNext;
		offset <= offsetNext;
		lTemp <= lTempNext;
	end

	assign busy = (state != stateIdle);

	////////////////////////////////////////////////////////////////////////////
	// Next state and operator drive
	////////////////////////////////////////////////////////////////////////////
	always_comb
	begin
		stateNext = state;
		iNext = i;
		indNext = ind;
		offsetNext = offset;
		lTempNext = lTemp;
		clampedInd = ind;
		// Idle operators sit at zero
		multA = '0;
		multB = '0;
		shrValue = '0;
		shrCount = '0;
		subA = '0;
		subB = '0;
		lMultA = '0;
		lMultB = '0;
		addA = '0;
		addB = '0;
		lShrValue = '0;
		lShrCount = '0;
		romAddr = '0;
		memReadAddr = '0;
		memWriteAddr = '0;
		memWriteData = '0;
		memWriteEn = 1'b0;
		done = 1'b0;

		case (state)
			stateIdle:
			begin
				iNext = '0;
				memReadAddr = {lsfBlock, 4'd0};
				if (start)
					stateNext = stateScale;
			end

			// freq = mult(lsf, 20861), ind = shr(freq, 8), offset = freq & 0xff
			stateScale:
			begin
				if (i >= lpcOrder)
				begin
					done = 1'b1;
					iNext = '0;
					stateNext = stateIdle;
				end
				else
				begin
					multA = memReadData[15:0];
					multB = freqScale;
					shrValue = multResult;
					shrCount = offsetShift;
					indNext = shrResult;
					offsetNext = multResult & 16'h00ff;
					stateNext = stateClamp;
				end
			end

			// Clip the segment index at 63, fetch its slope
			stateClamp:
			begin
				subA = ind;
				subB = maxIndex;
				if (!subResult[15])
					clampedInd = maxIndex;
				indNext = clampedInd;
				romAddr = slopeTableBase + {1'b0, clampedInd[5:0]};
				stateNext = stateSlope;
			end

			stateSlope:
			begin
				lMultA = romData;
				lMultB = offset;
				lTempNext = lMultResult;
				romAddr = cosTableBase + {1'b0, ind[5:0]};
				stateNext = stateWrite;
			end

			// lsp = add(table2[ind], extract_l(L_shr(L_tmp, 13)))
			stateWrite:
			begin
				lShrValue = lTemp;
				lShrCount = slopeShift;
				addA = romData;
				addB = lShrResult[15:0];
				memWriteAddr = {lspBlock, i};
				memWriteData = {{16{addResult[15]}}, addResult};
				memWriteEn = 1'b1;
				stateNext = stateAdvance;
			end

			stateAdvance:
			begin
				addA = {12'd0, i};
				addB = 16'd1;
				iNext = addResult[3:0];
				memReadAddr = {lsfBlock, iNext};
				stateNext = stateScale;
			end

			default:
			begin
				stateNext = stateIdle;
			end
		endcase
	end

endmodule

// File: rtl/lsfLspTop.sv
`timescale 1ns/10ps

module lsfLspTop
	import g729Pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic start,
	input  logic [blockWidth-1:0] lsfBlock,
	input  logic [blockWidth-1:0] lspBlock,
	input  logic hostWriteEn,
	input  logic [memAddrWidth-1:0] hostAddr,
	input  logic [31:0] hostWriteData,
	output logic [31:0] hostReadData,
	output logic busy,
	output logic done
);
	// Operator unit operands and results
	logic [15:0] multA, multB, multResult;
	logic [15:0] shrValue, shrCount, shrResult;
	logic [15:0] subA, subB, subResult;
	logic [15:0] lMultA, lMultB;
	logic [31:0] lMultResult;
	logic [15:0] addA, addB, addResult;
	logic [31:0] lShrValue, lShrResult;
	logic [15:0] lShrCount;

	// ROM and scratch memory
	logic [romAddrWidth-1:0] romAddr;
	logic [15:0] romData;
	logic [memAddrWidth-1:0] memReadAddr, memWriteAddr;
	logic [31:0] memReadData, memWriteData;
	logic memWriteEn;

	lsfLspConvert engine (
		.clk(clk), .reset(reset), .start(start),
		.lsfBlock(lsfBlock), .lspBlock(lspBlock),
		.multA(multA), .multB(multB), .multResult(multResult),
		.shrValue(shrValue), .shrCount(shrCount), .shrResult(shrResult),
		.subA(subA), .subB(subB), .subResult(subResult),
		.lMultA(lMultA), .lMultB(lMultB), .lMultResult(lMultResult),
		.addA(addA), .addB(addB), .addResult(addResult),
		.lShrValue(lShrValue), .lShrCount(lShrCount), .lShrResult(lShrResult),
		.romAddr(romAddr), .romData(romData),
		.memReadAddr(memReadAddr), .memReadData(memReadData),
		.memWriteAddr(memWriteAddr), .memWriteData(memWriteData),
		.memWriteEn(memWriteEn), .busy(busy), .done(done)
	);

	basicOps ops (
		.multA(multA), .multB(multB), .multResult(multResult),
		.shrValue(shrValue), .shrCount(shrCount), .shrResult(shrResult),
		.subA(subA), .subB(subB), .subResult(subResult),
		.lMultA(lMultA), .lMultB(lMultB), .lMultResult(lMultResult),
		.addA(addA), .addB(addB), .addResult(addResult),
		.lShrValue(lShrValue), .lShrCount(lShrCount), .lShrResult(lShrResult)
	);

	lspTableRom rom (.clk(clk), .romAddr(romAddr), .romData(romData));

	scratchMem mem (
		.clk(clk), .busy(busy),
		.memReadAddr(memReadAddr), .memReadData(memReadData),
		.memWriteAddr(memWriteAddr), .memWriteData(memWriteData), .memWriteEn(memWriteEn),
		.hostAddr(hostAddr), .hostWriteEn(hostWriteEn),
		.hostWriteData(hostWriteData), .hostReadData(hostReadData)
	);

endmodule

// File: rtl/lspTableRom.sv
`timescale 1ns/10ps

module lspTableRom
	import g729Pkg::*;
(
	input  logic clk,
	input  logic [romAddrWidth-1:0] romAddr,
	output logic [15:0] romData
);
	logic [romAddrWidth-1:0] slopeOffset;

	// Position inside the slope region
	assign slopeOffset = romAddr - slopeTableBase;

	// One cycle of read latency, same as a block RAM
	always_ff @(posedge clk)
	begin
		if (romAddr < slopeTableBase)
			romData <= cosTable[romAddr[5:0]];
		else
			romData <= slopeTable[slopeOffset[5:0]];
	end

endmodule

// File: rtl/scratchMem.sv
`timescale 1ns/10ps

module scratchMem
	import g729Pkg::*;
(
	input  logic clk,
	input  logic busy,
	input  logic [memAddrWidth-1:0] memReadAddr,
	output logic [31:0] memReadData,
	input  logic [memAddrWidth-1:0] memWriteAddr,
	input  logic [31:0] memWriteData,
	input  logic memWriteEn,
	input  logic [memAddrWidth-1:0] hostAddr,
	input  logic hostWriteEn,
	input  logic [31:0] hostWriteData,
	output logic [31:0] hostReadData
);
	logic [31:0] mem [0:(1 << memAddrWidth) - 1];
	logic [memAddrWidth-1:0] wrAddr;
	logic [31:0] wrData;
	logic wrEn;

	// Write side belongs to the engine while busy, host otherwise
	always_comb
	begin
		if (busy)
		begin
			wrAddr = memWriteAddr;
			wrData = memWriteData;
			wrEn = memWriteEn;
		end
		else
		begin
			wrAddr = hostAddr;
			wrData = hostWriteData;
			wrEn = hostWriteEn;
		end
	end

	// Engine read stays live so the first fetch can go out with start
	always_ff @(posedge clk)
	begin
		if (wrEn)
			mem[wrAddr] <= wrData;
		memReadData <= mem[memReadAddr];
		hostReadData <= mem[hostAddr];
	end

endmodule

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module lsfLspTb -f project.f \
	&& ./obj_dir/VlsfLspTb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "TEST OK" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

// File: tb/lsfLspAsserts.sv
`timescale 1ns/10ps

module lsfLspAsserts
(
	input logic clk,
	input logic reset,
	input logic busy,
	input logic done,
	input logic memWriteEn
);

	// Done is a single-cycle pulse
	doneOneCycle: assert property (@(posedge clk) disable iff (reset) done |=> !done)
		else $error("done stayed high for more than one cycle");

	// Engine writes only in the fourth cycle of a run or later
	writeInsideBusy: assert property (@(posedge clk) disable iff (reset)
		memWriteEn |-> busy && $past(busy, 3))
		else $error("memWriteEn asserted outside a running coefficient");

	// Done closes a full-length run
	doneInsideBusy: assert property (@(posedge clk) disable iff (reset)
		done |-> busy && $past(busy, 50))
		else $error("done asserted outside of a full run");

endmodule

bind lsfLspConvert lsfLspAsserts engineChecks (
	.clk(clk),
	.reset(reset),
	.busy(busy),
	.done(done),
	.memWriteEn(memWriteEn)
);

// File: tb/lsfLspTb.sv
`timescale 1ns/10ps

module lsfLspTb
	import g729Pkg::*;
();
	localparam int frameCount = 10;
	localparam int cycleLimit = frameCount * 400;

	logic clk;
	logic reset;
	logic start;
	logic [blockWidth-1:0] lsfBlock;
	logic [blockWidth-1:0] lspBlock;
	logic hostWriteEn;
	logic [memAddrWidth-1:0] hostAddr;
	logic [31:0] hostWriteData;
	logic [31:0] hostReadData;
	logic busy;
	logic done;

	logic [31:0] rngState = 32'd77;
	logic [31:0] shadow [0:127];
	logic [6:0] busyWrites [$];
	int cycleCount = 0;

	lsfLspTop UUT (
		.clk(clk), .reset(reset), .start(start),
		.lsfBlock(lsfBlock), .lspBlock(lspBlock),
		.hostWriteEn(hostWriteEn), .hostAddr(hostAddr),
		.hostWriteData(hostWriteData), .hostReadData(hostReadData),
		.busy(busy), .done(done)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Hard stop if a test hangs
	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit)
		begin
			$display("Timeout after %0d cycles", cycleLimit);
			$display("TEST FAILED");
			$fatal(1, "Cycle limit reached");
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Random source and reference model
	////////////////////////////////////////////////////////////////////////////
	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic nextRandom(output logic [31:0] value);
		rngState = xorshift(rngState);
		value = rngState;
	endtask

	// Initial memory image, every address bit shows up
	function automatic logic [31:0] fillWord(input logic [6:0] a);
		return {a, 1'b0, ~a, 1'b1, a, 2'b10, a};
	endfunction

	function automatic logic signed [15:0] saturate16(input longint v);
		if (v > 32767)
			return 16'sh7fff;
		else if (v < -32768)
			return 16'sh8000;
		else
			return 16'(v);
	endfunction

	function automatic logic signed [31:0] saturate32(input longint v);
		if (v > 64'sd2147483647)
			return 32'sh7fff_ffff;
		else if (v < -64'sd2147483648)
			return 32'sh8000_0000;
		else
			return 32'(v);
	endfunction

	function automatic logic signed [15:0] mulQ15(input logic signed [15:0] a,
		input logic signed [15:0] b);
		longint p;
		p = longint'(a) * longint'(b);
		return saturate16(p >>> 15);
	endfunction

	function automatic logic signed [31:0] mulDouble(input logic signed [15:0] a,
		input logic signed [15:0] b);
		longint p;
		p = 2 * longint'(a) * longint'(b);
		return saturate32(p);
	endfunction

	function automatic logic signed [15:0] addSat(input logic signed [15:0] a,
		input logic signed [15:0] b);
		return saturate16(longint'(a) + longint'(b));
	endfunction

	function automatic logic signed [15:0] subSat(input logic signed [15:0] a,
		input logic signed [15:0] b);
		return saturate16(longint'(a) - longint'(b));
	endfunction

	// One coefficient, Lsf_lsp2 from the G.729 reference
	function automatic logic [31:0] convertLsf(input logic signed [15:0] lsf);
		logic signed [15:0] freq;
		logic signed [15:0] ind;
		logic signed [15:0] offset;
		logic signed [31:0] lTmp;
		logic signed [31:0] lShifted;
		logic signed [15:0] lsp;
		logic [6:0] seg;
		freq = mulQ15(lsf, 16'sd20861);
		ind = freq >>> 8;
		offset = freq & 16'sh00ff;
		if (subSat(ind, 16'sd63) > 0)
			ind = 16'sd63;
		seg = ind[6:0];
		lTmp = mulDouble(slopeTable[seg[5:0]], offset);
		lShifted = lTmp >>> 13;
		lsp = addSat(cosTable[seg], lShifted[15:0]);
		return {{16{lsp[15]}}, lsp};
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Checks and host access
	////////////////////////////////////////////////////////////////////////////
	task automatic checkWord(input string testName, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected)
		else
		begin
			$display("Fail %s: expected %h, actual %h", testName, expected, actual);
			$display("TEST FAILED");
			$fatal(1, "Value mismatch in %s", testName);
		end
	endtask

	task automatic checkTrue(input logic ok, input string what);
		assert (ok === 1'b1)
		else
		begin
			$display("%s", what);
			$display("TEST FAILED");
			$fatal(1, "Check failed");
		end
	endtask

	task automatic writeWord(input logic [6:0] a, input logic [31:0] d);
		@(posedge clk);
		hostWriteEn <= 1'b1;
		hostAddr <= a;
		hostWriteData <= d;
		@(posedge clk);
		hostWriteEn <= 1'b0;
		shadow[a] = d;
	endtask

	task automatic readWord(input logic [6:0] a, output logic [31:0] d);
		@(posedge clk);
		hostWriteEn <= 1'b0;
		hostAddr <= a;
		@(posedge clk);
		@(negedge clk);
		d = hostReadData;
	endtask

	// Pulse start, follow busy and time done; optionally poke the DUT while busy
	task automatic runConversion(input logic disturb);
		int cycles;
		logic doneSeen;
		logic [31:0] r;
		logic [31:0] d;
		cycles = 0;
		doneSeen = 1'b0;
		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		while (!doneSeen)
		begin
			@(negedge clk);
			cycles++;
			checkTrue(busy, "busy went low before done");
			if (done === 1'b1)
				doneSeen = 1'b1;
			else if (cycles > 100)
				checkTrue(1'b0, "done never arrived after start");
			else
			begin
				@(posedge clk);
				if (disturb)
				begin
					nextRandom(r);
					nextRandom(d);
					start <= (cycles == 20);
					hostWriteEn <= (cycles >= 3 && cycles < 40);
					hostAddr <= r[6:0];
					hostWriteData <= d;
					if (cycles >= 3 && cycles < 40)
						busyWrites.push_back(r[6:0]);
				end
			end
		end
		checkWord("done latency", 32'd51, 32'(cycles));
		@(negedge clk);
		checkTrue(!busy && !done, "busy or done still high after the done cycle");
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////////////////////
	initial
	begin
		logic [31:0] r;
		logic [31:0] word;
		logic [15:0] freqs [0:9];
		logic [31:0] expected [0:9];
		logic [2:0] srcBlock;
		logic [2:0] dstBlock;
		string testName;

		reset = 1'b1;
		start = 1'b0;
		lsfBlock = '0;
		lspBlock = '0;
		hostWriteEn = 1'b0;
		hostAddr = '0;
		hostWriteData = '0;
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		checkTrue(!busy && !done && !UUT.memWriteEn, "control outputs high after reset");

		for (int a = 0; a < 128; a++)
			writeWord(7'(a), fillWord(7'(a)));

		for (int frame = 0; frame < frameCount; frame++)
		begin
			nextRandom(r);
			srcBlock = r[2:0];
			dstBlock = r[6:4];
			// Frame 6 converts in place
			if (frame == 6)
				dstBlock = srcBlock;
			else if (dstBlock == srcBlock)
				dstBlock = srcBlock + 3'd1;
			testName = (frame == 2) ? "clamped lsp" : (frame == 6) ? "in-place lsp" : "random lsp";
			@(posedge clk);
			lsfBlock <= srcBlock;
			lspBlock <= dstBlock;

			for (int k = 0; k < lpcOrder; k++)
			begin
				nextRandom(r);
				freqs[k] = {1'b0, r[14:0]};
				// Frame 2 sits at and above index 63, 25333 just below
				if (frame == 2)
					freqs[k] = (k == 0) ? 16'd25333 : (k == 1) ? 16'd25334 :
						(k == 9) ? 16'd32767 : 16'(25334 + (r % 7434));
				if (frame == 0 && k == 0)
					freqs[k] = 16'd0;
				writeWord({srcBlock, 4'(k)}, {16'd0, freqs[k]});
				expected[k] = convertLsf(freqs[k]);
			end

			busyWrites.delete();
			runConversion(frame == 4);

			for (int k = 0; k < lpcOrder; k++)
				shadow[{dstBlock, 4'(k)}] = expected[k];
			for (int k = 0; k < lpcOrder; k++)
			begin
				readWord({dstBlock, 4'(k)}, word);
				checkWord(testName, expected[k], word);
			end

			// Host writes issued during busy must not have landed
			foreach (busyWrites[n])
			begin
				readWord(busyWrites[n], word);
				checkWord("write during busy", shadow[busyWrites[n]], word);
			end
		end

		for (int a = 0; a < 128; a++)
		begin
			readWord(7'(a), word);
			checkWord("memory retention", shadow[a], word);
		end

		$display("TEST OK");
		$finish;
	end

endmodule
